//--- hdl/boardVga_macros.svh
`ifndef BOARDVGA_MACROS_SVH
`define BOARDVGA_MACROS_SVH

// 640x480 at 60 Hz, 25 MHz pixel clock.
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// Board of 3x3 cells.
`define BOARD_X0 128
`define BOARD_Y0 48
`define CELL_SIZE 128

`define GLYPH_MARGIN 16
`define X_STROKE 8
`define O_RIN 36
`define O_ROUT 44
`define CURSOR_W 4

`define ADDR_CELL0 8'h00
`define ADDR_CURSOR 8'h24

`endif

//--- hdl/boardVgaPkg.sv
`default_nettype none

package boardVgaPkg;

   typedef enum logic [1:0]
   {
      empty = 2'd0,
      x = 2'd1,
      o = 2'd2
   } symbolT;

   typedef logic [2:0] colorT; // {R, G, B}.

   localparam colorT black = 3'd0;
   localparam colorT blue = 3'd1;
   localparam colorT green = 3'd2;
   localparam colorT white = 3'd7;

   typedef struct packed
   {
      logic [9:0] col;
      logic [9:0] row;
   } pixelPosT;

   typedef struct packed
   {
      logic hSync; // Active low.
      logic vSync; // Active low.
      logic displayOn;
   } videoSyncT;

   localparam videoSyncT syncIdle = '{hSync: 1'b1, vSync: 1'b1, displayOn: 1'b0};

   typedef symbolT [8:0] boardT; // Row-major, cell 0 top left.

   // Packs as pwdata[4:0] of the cursor register.
   typedef struct packed
   {
      logic valid;
      logic [1:0] cellY;
      logic [1:0] cellX;
   } cursorT;

   typedef struct packed
   {
      logic psel;
      logic penable;
      logic pwrite;
      logic [7:0] paddr;
      logic [31:0] pwdata;
   } apbReqT;

   typedef struct packed
   {
      logic pready;
      logic pslverr;
      logic [31:0] prdata;
   } apbRspT;

endpackage

`default_nettype wire

//--- hdl/vgaTiming.sv
`timescale 1ns/1ps
`default_nettype none
`include "boardVga_macros.svh"

module vgaTiming
(
   input wire Clock,
   input wire arstN,
   output boardVgaPkg::pixelPosT pos,
   output boardVgaPkg::videoSyncT sync
);

   logic [9:0] colCnt;
   logic [9:0] rowCnt;
   logic colWrap;
   boardVgaPkg::videoSyncT syncNext;

   assign colWrap = (colCnt == 10'(`H_TOTAL - 1));

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         colCnt <= '0;
         rowCnt <= '0;
      end
      else
      begin
         colCnt <= colWrap ? '0 : colCnt + 10'd1;
         if (colWrap)
         begin
            rowCnt <= (rowCnt == 10'(`V_TOTAL - 1)) ? '0 : rowCnt + 10'd1;
         end
      end
   end

   // Sync windows for the pixel the counters point at.
   always_comb
   begin
      syncNext.hSync = !((colCnt >= 10'(`H_ACTIVE + `H_FRONT)) &&
                         (colCnt < 10'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
      syncNext.vSync = !((rowCnt >= 10'(`V_ACTIVE + `V_FRONT)) &&
                         (rowCnt < 10'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
      syncNext.displayOn = (colCnt < 10'(`H_ACTIVE)) && (rowCnt < 10'(`V_ACTIVE));
   end

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         pos <= '0;
         sync <= boardVgaPkg::syncIdle;
      end
      else
      begin
         pos <= '{col: colCnt, row: rowCnt};
         sync <= syncNext;
      end
   end

   // Horizontal sync pulse sits wholly in blanking.
   assert property (@(posedge Clock) disable iff (!arstN)
      !(!sync.hSync && sync.displayOn));

endmodule

`default_nettype wire

//--- hdl/videoAlignDelay.sv
`timescale 1ns/1ps
`default_nettype none

module videoAlignDelay
#(
   parameter type payloadT = logic,
   parameter int DEPTH = 2,
   parameter payloadT ResetValue = '0
)
(
   input wire Clock,
   input wire arstN,
   input wire payloadT din,
   output payloadT dout
);

   payloadT stages [DEPTH];

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            stages[i] <= ResetValue;
         end
      end
      else
      begin
         stages[0] <= din;
         for (int i = 1; i < DEPTH; i++)
         begin
            stages[i] <= stages[i-1];
         end
      end
   end

   assign dout = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- hdl/glyphRom.sv
`timescale 1ns/1ps
`default_nettype none
`include "boardVga_macros.svh"

module glyphRom
(
   input wire Clock,
   input wire arstN,
   input wire boardVgaPkg::pixelPosT localPos, // Cell-local, 0 to CELL_SIZE-1.
   output logic xPixel,
   output logic oPixel
);

   int c;
   int r;
   int diag;
   int anti;
   int dist2;
   logic inMargin;
   logic xHit;
   logic oHit;

   always_comb
   begin
      c = int'(localPos.col);
      r = int'(localPos.row);
      inMargin = (c >= `GLYPH_MARGIN) && (c <= `CELL_SIZE - 1 - `GLYPH_MARGIN) &&
                 (r >= `GLYPH_MARGIN) && (r <= `CELL_SIZE - 1 - `GLYPH_MARGIN);
      diag = c - r;
      anti = c + r - (`CELL_SIZE - 1);
      xHit = ((diag > -`X_STROKE) && (diag < `X_STROKE)) ||
             ((anti > -`X_STROKE) && (anti < `X_STROKE));
      // Ring around the cell centre.
      dist2 = (c - `CELL_SIZE/2) * (c - `CELL_SIZE/2) +
              (r - `CELL_SIZE/2) * (r - `CELL_SIZE/2);
      oHit = (dist2 >= `O_RIN * `O_RIN) && (dist2 < `O_ROUT * `O_ROUT);
   end

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         xPixel <= 1'b0;
         oPixel <= 1'b0;
      end
      else
      begin
         xPixel <= inMargin && xHit;
         oPixel <= inMargin && oHit;
      end
   end

endmodule

`default_nettype wire

//--- hdl/boardRegs.sv
`timescale 1ns/1ps
`default_nettype none
`include "boardVga_macros.svh"

module boardRegs
(
   input wire Clock,
   input wire arstN,
   input wire boardVgaPkg::apbReqT apbReq,
   output boardVgaPkg::apbRspT apbRsp,
   output boardVgaPkg::boardT board,
   output boardVgaPkg::cursorT cursor
);

   logic access;
   logic isCell;
   logic isCursor;
   logic [7:0] cellOffset;
   logic [3:0] cellIdx;
   boardVgaPkg::symbolT wrSym;

   assign access = apbReq.psel && apbReq.penable;
   assign cellOffset = apbReq.paddr - `ADDR_CELL0;
   assign cellIdx = cellOffset[5:2];
   assign isCell = (apbReq.paddr >= `ADDR_CELL0) && (cellOffset <= 8'h20) &&
                   (cellOffset[1:0] == 2'b00);
   assign isCursor = (apbReq.paddr == `ADDR_CURSOR);
   assign wrSym = (apbReq.pwdata[1:0] == 2'd3) ? boardVgaPkg::empty :
                  boardVgaPkg::symbolT'(apbReq.pwdata[1:0]);

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         board <= {9{boardVgaPkg::empty}};
         cursor <= '0;
      end
      else if (access && apbReq.pwrite)
      begin
         if (isCell)
            board[cellIdx] <= wrSym;
         else if (isCursor)
            cursor <= boardVgaPkg::cursorT'(apbReq.pwdata[4:0]);
      end
   end

   always_comb
   begin
      apbRsp.pready = 1'b1; // No wait states.
      apbRsp.pslverr = access && apbReq.pwrite && !(isCell || isCursor);
      apbRsp.prdata = '0;
      if (access && !apbReq.pwrite)
      begin
         if (isCell)
            apbRsp.prdata = {30'd0, board[cellIdx]};
         else if (isCursor)
            apbRsp.prdata = {27'd0, cursor};
      end
   end

   assert property (@(posedge Clock) disable iff (!arstN)
      (apbReq.psel && apbReq.penable) |-> $stable(apbReq.paddr));

   assert property (@(posedge Clock) disable iff (!arstN)
      !(apbReq.penable && !apbReq.psel));

endmodule

`default_nettype wire

//--- hdl/boardPixelGen.sv
`timescale 1ns/1ps
`default_nettype none
`include "boardVga_macros.svh"

module boardPixelGen
(
   input wire Clock,
   input wire arstN,
   input wire boardVgaPkg::pixelPosT pos,
   input wire boardVgaPkg::boardT board,
   input wire boardVgaPkg::cursorT cursor,
   output boardVgaPkg::colorT color
);

   logic inBoard;
   logic [9:0] boardCol;
   logic [9:0] boardRow;
   logic [1:0] cellX;
   logic [1:0] cellY;
   logic [3:0] cellIdx;
   logic [6:0] localCol;
   logic [6:0] localRow;
   logic onEdge;
   logic onCursor;
   boardVgaPkg::pixelPosT localPos;
   boardVgaPkg::symbolT sym;
   logic xPixel;
   logic oPixel;
   logic inBoardQ;
   logic cursorQ;
   boardVgaPkg::symbolT symQ;
   logic glyphOn;

   assign inBoard = (pos.col >= 10'(`BOARD_X0)) && (pos.col < 10'(`BOARD_X0 + 3*`CELL_SIZE)) &&
                    (pos.row >= 10'(`BOARD_Y0)) && (pos.row < 10'(`BOARD_Y0 + 3*`CELL_SIZE));
   assign boardCol = pos.col - 10'(`BOARD_X0);
   assign boardRow = pos.row - 10'(`BOARD_Y0);
   assign cellX = boardCol[8:7];
   assign cellY = boardRow[8:7];
   assign cellIdx = {2'b00, cellY} * 4'd3 + {2'b00, cellX};
   assign localCol = boardCol[6:0];
   assign localRow = boardRow[6:0];
   assign localPos = '{col: {3'b000, localCol}, row: {3'b000, localRow}};

   always_comb
   begin
      sym = boardVgaPkg::empty;
      if (inBoard)
         sym = board[cellIdx];
   end

   assign onEdge = (localCol < 7'(`CURSOR_W)) || (localCol >= 7'(`CELL_SIZE - `CURSOR_W)) ||
                   (localRow < 7'(`CURSOR_W)) || (localRow >= 7'(`CELL_SIZE - `CURSOR_W));
   // Cursor coordinate 3 never matches a cell inside the board.
   assign onCursor = inBoard && cursor.valid && onEdge &&
                     (cursor.cellX == cellX) && (cursor.cellY == cellY);

   glyphRom glyphRom_inst
   (
      .Clock(Clock),
      .arstN(arstN),
      .localPos(localPos),
      .xPixel(xPixel),
      .oPixel(oPixel)
   );

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
      begin
         inBoardQ <= 1'b0;
         cursorQ <= 1'b0;
         symQ <= boardVgaPkg::empty;
      end
      else
      begin
         inBoardQ <= inBoard;
         cursorQ <= onCursor;
         symQ <= sym;
      end
   end

   assign glyphOn = ((symQ == boardVgaPkg::x) && xPixel) ||
                    ((symQ == boardVgaPkg::o) && oPixel);

   always_ff @(posedge Clock or negedge arstN)
   begin
      if (!arstN)
         color <= boardVgaPkg::black;
      else if (!inBoardQ)
         color <= boardVgaPkg::black;
      else if (cursorQ)
         color <= boardVgaPkg::green;
      else if (glyphOn)
         color <= boardVgaPkg::blue;
      else
         color <= boardVgaPkg::white;
   end

endmodule

`default_nettype wire

//--- hdl/boardDisplay.sv
`timescale 1ns/1ps
`default_nettype none

module boardDisplay
(
   input wire Clock,
   input wire arstN,
   input wire boardVgaPkg::apbReqT apbReq,
   output boardVgaPkg::apbRspT apbRsp,
   output boardVgaPkg::colorT vgaColor,
   output logic hSync,
   output logic vSync
);

   boardVgaPkg::pixelPosT pos;
   boardVgaPkg::videoSyncT sync;
   boardVgaPkg::videoSyncT syncAligned;
   boardVgaPkg::boardT board;
   boardVgaPkg::cursorT cursor;

   vgaTiming vgaTiming_inst
   (
      .Clock(Clock),
      .arstN(arstN),
      .pos(pos),
      .sync(sync)
   );

   boardRegs boardRegs_inst
   (
      .Clock(Clock),
      .arstN(arstN),
      .apbReq(apbReq),
      .apbRsp(apbRsp),
      .board(board),
      .cursor(cursor)
   );

   boardPixelGen boardPixelGen_inst
   (
      .Clock(Clock),
      .arstN(arstN),
      .pos(pos),
      .board(board),
      .cursor(cursor),
      .color(vgaColor)
   );

   // Matches the two-cycle pixel pipeline.
   videoAlignDelay #(
      .payloadT(boardVgaPkg::videoSyncT),
      .DEPTH(2),
      .ResetValue(boardVgaPkg::syncIdle)
   ) videoAlignDelay_inst
   (
      .Clock(Clock),
      .arstN(arstN),
      .din(sync),
      .dout(syncAligned)
   );

   assign hSync = syncAligned.hSync;
   assign vSync = syncAligned.vSync;

endmodule

`default_nettype wire

//--- verification/boardDisplayTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "boardVga_macros.svh"

module boardDisplayTb;

   localparam int frameCycles = `H_TOTAL * `V_TOTAL;
   localparam int timeoutCycles = 6 * frameCycles + 1000;
   localparam int reportLimit = 20; // Mismatch lines printed per test.

   logic Clock = 1'b0;
   logic arstN;
   boardVgaPkg::apbReqT apbReq;
   boardVgaPkg::apbRspT apbRsp;
   boardVgaPkg::colorT vgaColor;
   logic hSync;
   logic vSync;

   boardVgaPkg::boardT refBoard;
   boardVgaPkg::cursorT refCursor;
   string curTest;
   int errorCount = 0;
   int testErrStart = 0;
   int testPass = 0;
   int testFail = 0;
   int frameCount = 0;
   int cycleCount = 0;

   int scanCol = 0;
   int scanRow = 0;
   logic scanLocked = 1'b0;
   logic prevVSync = 1'b1;
   string colorTag;
   string hTag;
   string vTag;

   boardDisplay boardDisplay_inst
   (
      .Clock(Clock),
      .arstN(arstN),
      .apbReq(apbReq),
      .apbRsp(apbRsp),
      .vgaColor(vgaColor),
      .hSync(hSync),
      .vSync(vSync)
   );

   always #4 Clock = ~Clock;

   function automatic int absInt(input int v);
      return (v < 0) ? -v : v;
   endfunction

   // Screen pixel colour from the board rules.
   function automatic boardVgaPkg::colorT expectedColor(input int col, input int row,
      input boardVgaPkg::boardT b, input boardVgaPkg::cursorT cur);
      int cx;
      int cy;
      int lc;
      int lr;
      int d2;
      logic inGlyph;
      logic xOn;
      logic oOn;
      boardVgaPkg::symbolT s;
      if (col < `BOARD_X0 || col >= `BOARD_X0 + 3 * `CELL_SIZE ||
          row < `BOARD_Y0 || row >= `BOARD_Y0 + 3 * `CELL_SIZE)
         return boardVgaPkg::black;
      cx = (col - `BOARD_X0) / `CELL_SIZE;
      cy = (row - `BOARD_Y0) / `CELL_SIZE;
      lc = (col - `BOARD_X0) % `CELL_SIZE;
      lr = (row - `BOARD_Y0) % `CELL_SIZE;
      if (cur.valid && int'(cur.cellX) == cx && int'(cur.cellY) == cy &&
          (lc < `CURSOR_W || lc >= `CELL_SIZE - `CURSOR_W ||
           lr < `CURSOR_W || lr >= `CELL_SIZE - `CURSOR_W))
         return boardVgaPkg::green;
      s = b[cy * 3 + cx];
      inGlyph = lc >= `GLYPH_MARGIN && lc <= `CELL_SIZE - 1 - `GLYPH_MARGIN &&
                lr >= `GLYPH_MARGIN && lr <= `CELL_SIZE - 1 - `GLYPH_MARGIN;
      xOn = inGlyph && (absInt(lc - lr) < `X_STROKE ||
                        absInt(lc + lr - (`CELL_SIZE - 1)) < `X_STROKE);
      d2 = (lc - 64) * (lc - 64) + (lr - 64) * (lr - 64);
      oOn = inGlyph && d2 >= `O_RIN * `O_RIN && d2 < `O_ROUT * `O_ROUT;
      if ((s == boardVgaPkg::x && xOn) || (s == boardVgaPkg::o && oOn))
         return boardVgaPkg::blue;
      return boardVgaPkg::white;
   endfunction

   task automatic checkColor(input string name, input boardVgaPkg::colorT expected,
      input boardVgaPkg::colorT actual);
      if (actual !== expected)
      begin
         errorCount++;
         if (errorCount - testErrStart <= reportLimit)
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic checkSync(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         errorCount++;
         if (errorCount - testErrStart <= reportLimit)
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic checkApb(input string name, input boardVgaPkg::apbRspT expected,
      input boardVgaPkg::apbRspT actual);
      if (actual !== expected)
      begin
         errorCount++;
         $display("FAILED %s: expected ready %b err %b data %h, actual ready %b err %b data %h",
            name, expected.pready, expected.pslverr, expected.prdata,
            actual.pready, actual.pslverr, actual.prdata);
      end
   endtask

   task automatic comparePixel();
      if (scanCol == 0)
      begin
         colorTag = $sformatf("%s color row %0d", curTest, scanRow);
         hTag = $sformatf("%s hSync row %0d", curTest, scanRow);
         vTag = $sformatf("%s vSync row %0d", curTest, scanRow);
      end
      checkSync(hTag, !(scanCol >= `H_ACTIVE + `H_FRONT &&
                        scanCol < `H_ACTIVE + `H_FRONT + `H_SYNC), hSync);
      checkSync(vTag, !(scanRow >= `V_ACTIVE + `V_FRONT &&
                        scanRow < `V_ACTIVE + `V_FRONT + `V_SYNC), vSync);
      if (scanCol < `H_ACTIVE && scanRow < `V_ACTIVE)
         checkColor(colorTag, expectedColor(scanCol, scanRow, refBoard, refCursor), vgaColor);
      if (scanCol == 0 && scanRow == `V_ACTIVE)
         frameCount++; // Last active pixel is done.
   endtask

   // First vSync fall marks column 0 of row 490.
   always @(posedge Clock)
   begin
      if (arstN)
      begin
         if (scanLocked)
         begin
            scanCol++;
            if (scanCol == `H_TOTAL)
            begin
               scanCol = 0;
               scanRow = (scanRow == `V_TOTAL - 1) ? 0 : scanRow + 1;
            end
         end
         else if (prevVSync && !vSync)
         begin
            scanLocked = 1'b1;
            scanCol = 0;
            scanRow = `V_ACTIVE + `V_FRONT;
         end
         if (scanLocked)
            comparePixel();
         prevVSync = vSync;
      end
   end

   always @(posedge Clock)
   begin
      cycleCount++;
      if (cycleCount >= timeoutCycles)
      begin
         $display("Run stopped after %0d cycles while in %s.", cycleCount, curTest);
         $display("TEST FAILED");
         $finish;
      end
   end

   task automatic apbTransfer(input logic write, input logic [7:0] addr,
      input logic [31:0] data, output boardVgaPkg::apbRspT rsp);
      @(posedge Clock);
      apbReq <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
      @(posedge Clock);
      apbReq.penable <= 1'b1;
      @(posedge Clock);
      while (!apbRsp.pready)
         @(posedge Clock);
      rsp = apbRsp;
      apbReq <= '0;
   endtask

   task automatic writeReg(input string name, input logic [7:0] addr,
      input logic [31:0] data, input logic expectErr);
      boardVgaPkg::apbRspT rsp;
      boardVgaPkg::apbRspT expected;
      apbTransfer(1'b1, addr, data, rsp);
      rsp.prdata = '0; // Write responses carry no data.
      expected = '{pready: 1'b1, pslverr: expectErr, prdata: 32'd0};
      checkApb(name, expected, rsp);
   endtask

   task automatic readReg(input string name, input logic [7:0] addr, input logic [31:0] expData);
      boardVgaPkg::apbRspT rsp;
      boardVgaPkg::apbRspT expected;
      apbTransfer(1'b0, addr, 32'd0, rsp);
      expected = '{pready: 1'b1, pslverr: 1'b0, prdata: expData};
      checkApb(name, expected, rsp);
   endtask

   task automatic setCell(input int idx, input int code);
      writeReg($sformatf("write cell %0d", idx), 8'(`ADDR_CELL0 + 4 * idx), 32'(code), 1'b0);
      refBoard[idx] = (code == 3) ? boardVgaPkg::empty : boardVgaPkg::symbolT'(code);
   endtask

   task automatic beginTest(input string name);
      curTest = name;
      testErrStart = errorCount;
   endtask

   task automatic endTest();
      if (errorCount == testErrStart)
      begin
         testPass++;
         $display("PASS %s", curTest);
      end
      else
      begin
         testFail++;
         $display("FAIL %s with %0d mismatches", curTest, errorCount - testErrStart);
      end
   endtask

   task automatic waitFrameEnd();
      int target;
      target = frameCount + 1;
      wait (frameCount >= target);
   endtask

   initial
   begin
      int pattern [9] = '{2, 1, 0, 0, 2, 2, 1, 1, 2}; // O X - / - O O / X X O.
      int cx;
      int cy;
      logic [31:0] badData;
      apbReq = '0;
      arstN = 1'b0;
      refBoard = {9{boardVgaPkg::empty}};
      refCursor = '0;
      curTest = "reset";
      void'($urandom(93458));
      repeat (4) @(posedge Clock);
      arstN <= 1'b1;

      beginTest("blank board after reset");
      waitFrameEnd();
      endTest();

      beginTest("fixed pattern");
      for (int i = 0; i < 9; i++)
         setCell(i, pattern[i]);
      waitFrameEnd();
      endTest();

      beginTest("random symbols");
      for (int i = 0; i < 9; i++)
         setCell(i, $urandom % 4);
      for (int i = 0; i < 9; i++)
         readReg($sformatf("read cell %0d", i), 8'(`ADDR_CELL0 + 4 * i), 32'(refBoard[i]));
      waitFrameEnd();
      endTest();

      beginTest("cursor shown");
      cx = $urandom % 3;
      cy = $urandom % 3;
      writeReg("cursor write", `ADDR_CURSOR, {27'd0, 1'b1, 2'(cy), 2'(cx)}, 1'b0);
      refCursor = '{valid: 1'b1, cellY: 2'(cy), cellX: 2'(cx)};
      readReg("cursor read", `ADDR_CURSOR, {27'd0, refCursor});
      waitFrameEnd();
      endTest();

      // Border goes away and the unmapped write leaves the picture alone.
      beginTest("cursor cleared and bad address");
      writeReg("cursor clear", `ADDR_CURSOR, {27'd0, 1'b0, 2'(cy), 2'(cx)}, 1'b0);
      refCursor.valid = 1'b0;
      // Would show up if stored in cell 0 or in the cursor.
      badData = (refBoard[0] == boardVgaPkg::x) ? 32'h12 : 32'h11;
      writeReg("unmapped write", 8'h40, badData, 1'b1);
      waitFrameEnd();
      endTest();

      $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
         testPass, testFail, errorCount);
      if (errorCount == 0 && testFail == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/boardVgaPkg.sv
hdl/vgaTiming.sv
hdl/videoAlignDelay.sv
hdl/glyphRom.sv
hdl/boardRegs.sv
hdl/boardPixelGen.sv
hdl/boardDisplay.sv
verification/boardDisplayTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module boardDisplayTb \
   --Mdir obj_dir -o boardDisplayTb > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/boardDisplayTb > sim.log 2>&1
grep -q "TEST OK" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
